/* otp_fault_svc.f */
hw/otp_fault_pkg.sv
hw/svc_cmd_pkg.sv
hw/svc_cmd_decoder.sv
hw/otp_partition.sv
hw/otp_wb_frontend.sv
hw/otp_status_collector.sv
hw/otp_fault_svc_top.sv
testbench/tb_otp_fault_svc.sv

/* Makefile */
# Verilator build and run for the fuse test-service block

VERILATOR ?= verilator
TOP       ?= tb_otp_fault_svc
FILELIST  ?= otp_fault_svc.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_otp_fault_svc.sv */
/*
  Directed testbench for the fuse test-service block with NUM_PART = 8 and
  RST_HOLD = 10. Expected values come from a local model of the data words,
  the digests and the lock mask. The status checks assume 8 partitions.
*/

`default_nettype none

module tb_otp_fault_svc import otp_fault_pkg::*, svc_cmd_pkg::*; ();

  localparam int NUM_PART = 8;
  localparam int RST_HOLD = 10;
  // About 100 bus accesses of 3 cycles each, with six times that as margin
  localparam int TXN_BUDGET     = 100;
  localparam int TIMEOUT_CYCLES = 6 * (TXN_BUDGET * 3 + RST_HOLD + 10);

  logic              clk = 1'b0;
  logic              cptra_rst_b;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [WB_DW-1:0]  wb_wdat;
  logic              wb_ack;
  logic [WB_DW-1:0]  wb_rdat;
  logic              cmd_valid;
  svc_cmd_e          cmd;
  logic              alert_corr;
  logic              alert_fatal;
  logic              lc_rst_b;

  // Model of what the fuse array should hold
  otp_word_t           exp_data   [NUM_PART];
  otp_word_t           exp_digest [NUM_PART];
  logic [NUM_PART-1:0] lock_mask;
  logic [31:0]         lfsr_q;
  int                  errors    = 0;
  int                  checks    = 0;
  int                  cycle_cnt = 0;

  otp_fault_svc_top #(.NUM_PART(NUM_PART), .RST_HOLD(RST_HOLD)) UUT (
    .clk          (clk),
    .cptra_rst_b  (cptra_rst_b),
    .wb_cyc_i     (wb_cyc),
    .wb_stb_i     (wb_stb),
    .wb_we_i      (wb_we),
    .wb_adr_i     (wb_adr),
    .wb_dat_i     (wb_wdat),
    .wb_ack_o     (wb_ack),
    .wb_dat_o     (wb_rdat),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .alert_corr_o (alert_corr),
    .alert_fatal_o(alert_fatal),
    .lc_rst_b_o   (lc_rst_b)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_word(output otp_word_t w);
    for (int b = 0; b < 16; b++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w[b]   = lfsr_q[0];
    end
  endtask

  function automatic logic [ADDR_W-1:0] data_adr(input int i);
    return ADDR_DATA_BASE + ADDR_W'(i);
  endfunction

  function automatic logic [ADDR_W-1:0] digest_adr(input int i);
    return ADDR_DIGEST_BASE + ADDR_W'(i);
  endfunction

  task automatic wb_write(input logic [ADDR_W-1:0] adr, input logic [WB_DW-1:0] dat);
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= 1'b1;
    wb_adr  <= adr;
    wb_wdat <= dat;
    do @(posedge clk); while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input logic [ADDR_W-1:0] adr, output logic [WB_DW-1:0] dat);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do @(posedge clk); while (!wb_ack);
    dat = wb_rdat;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic send_cmd(input svc_cmd_e c);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Locked partitions read inverted while an uncorrectable fault is applied
  task automatic check_all_data(input logic invert_locked);
    logic [WB_DW-1:0] rd;
    otp_word_t        exp;
    for (int i = 0; i < NUM_PART; i++) begin
      wb_read(data_adr(i), rd);
      exp = (invert_locked && lock_mask[i]) ? ~exp_data[i] : exp_data[i];
      check($sformatf("data %0d", i), rd, {16'h0000, exp});
    end
  endtask

  task automatic check_status(input logic [31:0] exp);
    logic [WB_DW-1:0] rd;
    wb_read(ADDR_STATUS, rd);
    check("status", rd, exp);
  endtask

  task automatic check_alerts(input logic exp_corr, input logic exp_fatal);
    check("alert_corr_o", {31'd0, alert_corr}, {31'd0, exp_corr});
    check("alert_fatal_o", {31'd0, alert_fatal}, {31'd0, exp_fatal});
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic program_and_readback();
    for (int i = 0; i < NUM_PART; i++) begin
      rand_word(exp_data[i]);
      wb_write(data_adr(i), {16'h0000, exp_data[i]});
    end
    check_all_data(1'b0);
    check_status(32'h0000_0000);
  endtask

  task automatic lock_even_partitions();
    logic [WB_DW-1:0] rd;
    otp_word_t        w;
    for (int i = 0; i < NUM_PART; i += 2) begin
      rand_word(w);
      exp_digest[i] = {1'b1, w[14:0]};
      lock_mask[i]  = 1'b1;
      wb_write(digest_adr(i), {16'h0000, exp_digest[i]});
    end
    for (int i = 0; i < NUM_PART; i++) begin
      rand_word(w);
      wb_write(data_adr(i), {16'h0000, w});
      if (!lock_mask[i]) exp_data[i] = w;
    end
    check_all_data(1'b0);
    for (int i = 0; i < NUM_PART; i += 2) begin
      wb_read(digest_adr(i), rd);
      check($sformatf("digest %0d", i), rd, {16'h0000, exp_digest[i]});
    end
  endtask

  task automatic inject_corr_fault();
    send_cmd(CMD_CORR_FAULT);
    check_all_data(1'b0);
    check_status({15'd0, 1'b1, 8'h00, lock_mask});
    check_alerts(1'b1, 1'b0);
    // A fault is already held, so this one must not take effect
    send_cmd(CMD_UNCORR_FAULT);
    check_all_data(1'b0);
    check_status({15'd0, 1'b1, 8'h00, lock_mask});
  endtask

  task automatic inject_uncorr_fault();
    send_cmd(CMD_RELEASE_FAULT);
    check_status({15'd0, 1'b0, 8'h00, lock_mask});
    send_cmd(CMD_UNCORR_FAULT);
    check_all_data(1'b1);
    check_status({15'd0, 1'b1, lock_mask, lock_mask});
    check_alerts(1'b1, 1'b1);
  endtask

  task automatic pulse_lc_reset();
    logic [WB_DW-1:0] rd;
    int               low_cycles;
    low_cycles = 0;
    send_cmd(CMD_LC_RESET);
    while (lc_rst_b) @(posedge clk);
    while (!lc_rst_b) begin
      low_cycles++;
      @(posedge clk);
    end
    check("lc reset length", 32'(low_cycles), 32'(RST_HOLD));
    check_alerts(1'b0, 1'b0);
    check_status(32'h0000_0000);
    check_all_data(1'b0);
    for (int i = 0; i < NUM_PART; i += 2) begin
      wb_read(digest_adr(i), rd);
      check($sformatf("kept digest %0d", i), rd, {16'h0000, exp_digest[i]});
    end
    // Partition 0 must still be locked
    wb_write(data_adr(0), {16'h0000, ~exp_data[0]});
    wb_read(data_adr(0), rd);
    check("locked data 0", rd, {16'h0000, exp_data[0]});
  endtask

  initial begin
    cptra_rst_b <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_stb      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= '0;
    wb_wdat     <= '0;
    cmd_valid   <= 1'b0;
    cmd         <= CMD_RELEASE_FAULT;
    lfsr_q    = 32'hdeeb_0a9d;
    lock_mask = '0;
    repeat (4) @(posedge clk);
    cptra_rst_b <= 1'b1;
    check_alerts(1'b0, 1'b0);
    program_and_readback();
    lock_even_partitions();
    inject_corr_fault();
    inject_uncorr_fault();
    pulse_lc_reset();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_otp_fault_svc

`default_nettype wire

/* hw/otp_fault_svc_top.sv */
/*
  Fuse test-service top level. NUM_PART sets the partition count (1 to 8),
  RST_HOLD the length of the lifecycle reset pulse in cycles.
*/

`default_nettype none

module otp_fault_svc_top import otp_fault_pkg::*, svc_cmd_pkg::*; #(
  parameter int NUM_PART = 8,
  parameter int RST_HOLD = 10
) (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [WB_DW-1:0]  wb_dat_i,
  output logic              wb_ack_o,
  output logic [WB_DW-1:0]  wb_dat_o,
  input  logic              cmd_valid_i,
  input  svc_cmd_e          cmd_i,
  output logic              alert_corr_o,
  output logic              alert_fatal_o,
  output logic              lc_rst_b_o
);

  part_wr_t          part_wr     [NUM_PART];
  part_stat_t        part_stat   [NUM_PART];
  otp_word_t         part_digest [NUM_PART];
  fault_req_t        fault_req;
  logic              fault_active;
  logic [ADDR_W-1:0] rd_adr;
  logic [WB_DW-1:0]  rd_dat;

  otp_wb_frontend #(.NUM_PART(NUM_PART)) u_frontend (
    .clk        (clk),
    .cptra_rst_b(cptra_rst_b),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_o   (wb_ack_o),
    .wb_dat_o   (wb_dat_o),
    .part_wr_o  (part_wr),
    .rd_adr_o   (rd_adr),
    .rd_dat_i   (rd_dat)
  );

  for (genvar i = 0; i < NUM_PART; i++) begin : g_part
    otp_partition #(.NUM_PART(NUM_PART)) u_part (
      .clk        (clk),
      .cptra_rst_b(cptra_rst_b),
      .lc_rst_b_i (lc_rst_b_o),
      .wr_i       (part_wr[i]),
      .fault_req_i(fault_req),
      .stat_o     (part_stat[i]),
      .digest_o   (part_digest[i])
    );
  end

  otp_status_collector #(.NUM_PART(NUM_PART)) u_collector (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .lc_rst_b_i    (lc_rst_b_o),
    .stat_i        (part_stat),
    .digest_i      (part_digest),
    .fault_active_i(fault_active),
    .rd_adr_i      (rd_adr),
    .rd_dat_o      (rd_dat),
    .alert_corr_o  (alert_corr_o),
    .alert_fatal_o (alert_fatal_o)
  );

  svc_cmd_decoder #(.RST_HOLD(RST_HOLD)) u_decoder (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .fault_req_o   (fault_req),
    .fault_active_o(fault_active),
    .lc_rst_b_o    (lc_rst_b_o)
  );

endmodule : otp_fault_svc_top

`default_nettype wire

/* hw/otp_status_collector.sv */
/*
  Collects partition status into sticky alert bits and builds the read mux.
  The sticky bits clear on cptra_rst_b and while the lifecycle reset is low.
*/

`default_nettype none

module otp_status_collector import otp_fault_pkg::*; #(
  parameter int NUM_PART = 8
) (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic              lc_rst_b_i,
  input  part_stat_t        stat_i [NUM_PART],
  input  otp_word_t         digest_i [NUM_PART],
  input  logic              fault_active_i,
  input  logic [ADDR_W-1:0] rd_adr_i,
  output logic [WB_DW-1:0]  rd_dat_o,
  output logic              alert_corr_o,
  output logic              alert_fatal_o
);

  logic [NUM_PART-1:0] corr_now;
  logic [NUM_PART-1:0] uncorr_now;
  logic [NUM_PART-1:0] corr_q;
  logic [NUM_PART-1:0] uncorr_q;
  logic [MAX_PART-1:0] corr_ext;
  logic [MAX_PART-1:0] uncorr_ext;

  always_comb begin
    for (int i = 0; i < NUM_PART; i++) begin
      corr_now[i]   = stat_i[i].corr;
      uncorr_now[i] = stat_i[i].uncorr;
    end
  end

  // ----------------------------------------------------------
  // Sticky alerts
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      corr_q   <= '0;
      uncorr_q <= '0;
    end else if (!lc_rst_b_i) begin
      corr_q   <= '0;
      uncorr_q <= '0;
    end else begin
      corr_q   <= corr_q | corr_now;
      uncorr_q <= uncorr_q | uncorr_now;
    end
  end

  assign alert_corr_o  = |corr_q;
  assign alert_fatal_o = |uncorr_q;

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  always_comb begin
    corr_ext                   = '0;
    uncorr_ext                 = '0;
    corr_ext[NUM_PART-1:0]     = corr_q;
    uncorr_ext[NUM_PART-1:0]   = uncorr_q;
    rd_dat_o                   = '0;
    if (rd_adr_i == ADDR_STATUS) begin
      rd_dat_o = {{(WB_DW - 1 - 2 * MAX_PART){1'b0}}, fault_active_i, uncorr_ext, corr_ext};
    end
    for (int i = 0; i < NUM_PART; i++) begin
      if (rd_adr_i == ADDR_DATA_BASE + ADDR_W'(i)) begin
        rd_dat_o = {16'h0000, stat_i[i].rdata};
      end
      if (rd_adr_i == ADDR_DIGEST_BASE + ADDR_W'(i)) begin
        rd_dat_o = {16'h0000, digest_i[i]};
      end
    end
  end

endmodule : otp_status_collector

`default_nettype wire

/* hw/otp_wb_frontend.sv */
/*
  Wishbone classic slave with a registered single-cycle ack. Writes go to the
  partitions as one-cycle strobes, and only bits 15:0 of the write data are used.
  Read data comes from the collector and is captured together with ack.
*/

`default_nettype none

module otp_wb_frontend import otp_fault_pkg::*; #(
  parameter int NUM_PART = 8
) (
  input  logic              clk,
  input  logic              cptra_rst_b,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [WB_DW-1:0]  wb_dat_i,
  output logic              wb_ack_o,
  output logic [WB_DW-1:0]  wb_dat_o,
  output part_wr_t          part_wr_o [NUM_PART],
  output logic [ADDR_W-1:0] rd_adr_o,
  input  logic [WB_DW-1:0]  rd_dat_i
);

  logic             ack_q;
  logic [WB_DW-1:0] dat_q;
  logic             req_new;

  // A request is new only in the cycle before its ack, which keeps a held
  // request from being served twice
  assign req_new = wb_cyc_i && wb_stb_i && !ack_q;

  // ----------------------------------------------------------
  // Ack and read data
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  always_ff @(posedge clk) begin
    if (req_new && !wb_we_i) begin
      dat_q <= rd_dat_i;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;
  assign rd_adr_o = wb_adr_i;

  // ----------------------------------------------------------
  // Partition write strobes
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PART; i++) begin
      part_wr_o[i].data_we   = req_new && wb_we_i &&
                               (wb_adr_i == ADDR_DATA_BASE + ADDR_W'(i));
      part_wr_o[i].digest_we = req_new && wb_we_i &&
                               (wb_adr_i == ADDR_DIGEST_BASE + ADDR_W'(i));
      part_wr_o[i].wdata     = wb_dat_i[15:0];
    end
  end

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("ack raised without a bus request");

endmodule : otp_wb_frontend

`default_nettype wire

/* hw/otp_partition.sv */
/*
  One fuse partition with a data word, a golden copy and a digest, all blank (0)
  after reset. A nonzero digest locks it until cptra_rst_b. Faults apply only to
  a locked partition and are masked while the lifecycle reset is low.
*/

`default_nettype none

module otp_partition import otp_fault_pkg::*, svc_cmd_pkg::*; #(
  parameter int NUM_PART = 8
) (
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       lc_rst_b_i,
  input  part_wr_t   wr_i,
  input  fault_req_t fault_req_i,
  output part_stat_t stat_o,
  output otp_word_t  digest_o
);

  if ((NUM_PART < 1) || (NUM_PART > MAX_PART)) begin : g_bad_num_part
    $error("NUM_PART must lie between 1 and MAX_PART");
  end

  otp_word_t word_q;
  otp_word_t golden_q;
  otp_word_t digest_q;
  logic      locked_q;

  otp_word_t fault_word;
  otp_word_t diff;
  logic      one_bit;
  logic      many_bits;

  // ----------------------------------------------------------
  // Fuse storage and lock
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      word_q   <= '0;
      golden_q <= '0;
      digest_q <= '0;
      locked_q <= 1'b0;
    end else if (!locked_q) begin
      if (wr_i.data_we) begin
        word_q   <= wr_i.wdata;
        golden_q <= wr_i.wdata;
      end
      if (wr_i.digest_we) begin
        digest_q <= wr_i.wdata;
        locked_q <= (wr_i.wdata != '0);
      end
    end
  end

  // ----------------------------------------------------------
  // Fault application and classification
  // ----------------------------------------------------------
  always_comb begin
    fault_word = word_q;
    if (locked_q && lc_rst_b_i) begin
      case (fault_req_i.kind)
        FAULT_CORR:   fault_word[0] = ~word_q[0];
        FAULT_UNCORR: fault_word    = ~word_q;
        default:      fault_word    = word_q;
      endcase
    end
  end

  // Distance to the golden copy decides whether the word can be repaired
  assign diff      = fault_word ^ golden_q;
  assign one_bit   = $onehot(diff);
  assign many_bits = (diff != '0) && !one_bit;

  always_comb begin
    stat_o.rdata  = one_bit ? golden_q : fault_word;
    stat_o.locked = locked_q;
    stat_o.corr   = one_bit;
    stat_o.uncorr = many_bits;
  end

  assign digest_o = digest_q;

  a_class_excl: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    !(stat_o.corr && stat_o.uncorr))
    else $error("partition flagged both correctable and uncorrectable");

endmodule : otp_partition

`default_nettype wire

/* hw/svc_cmd_decoder.sv */
/*
  Service command decoder. It holds one fault kind until release and times the
  lifecycle reset pulse. RST_HOLD must be at least 1. Commands that arrive while
  the pulse runs are dropped.
*/

`default_nettype none

module svc_cmd_decoder import svc_cmd_pkg::*; #(
  parameter int RST_HOLD = 10
) (
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       cmd_valid_i,
  input  svc_cmd_e   cmd_i,
  output fault_req_t fault_req_o,
  output logic       fault_active_o,
  output logic       lc_rst_b_o
);

  localparam int CNT_W = $clog2(RST_HOLD + 1);

  fault_kind_e      fault_kind_q;
  logic             rst_active_q;
  logic [CNT_W-1:0] rst_cnt_q;

  // ----------------------------------------------------------
  // Lifecycle reset pulse
  // ----------------------------------------------------------
  // The counter starts at 1 in the first low cycle, so the pulse ends
  // after the cycle in which it reaches RST_HOLD
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_active_q <= 1'b0;
      rst_cnt_q    <= '0;
    end else if (rst_active_q) begin
      if (rst_cnt_q == CNT_W'(RST_HOLD)) begin
        rst_active_q <= 1'b0;
        rst_cnt_q    <= '0;
      end else begin
        rst_cnt_q <= rst_cnt_q + 1'b1;
      end
    end else if (cmd_valid_i && (cmd_i == CMD_LC_RESET)) begin
      rst_active_q <= 1'b1;
      rst_cnt_q    <= CNT_W'(1);
    end
  end

  assign lc_rst_b_o = ~rst_active_q;

  // ----------------------------------------------------------
  // Held fault request
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_kind_q <= FAULT_NONE;
    end else if (rst_active_q) begin
      // The lifecycle reset wipes any injected fault
      fault_kind_q <= FAULT_NONE;
    end else if (cmd_valid_i) begin
      case (cmd_i)
        CMD_CORR_FAULT: begin
          if (fault_kind_q == FAULT_NONE) fault_kind_q <= FAULT_CORR;
        end
        CMD_UNCORR_FAULT: begin
          if (fault_kind_q == FAULT_NONE) fault_kind_q <= FAULT_UNCORR;
        end
        CMD_RELEASE_FAULT: begin
          fault_kind_q <= FAULT_NONE;
        end
        default: begin
        end
      endcase
    end
  end

  assign fault_req_o.kind = fault_kind_q;
  assign fault_active_o   = (fault_kind_q != FAULT_NONE);

  a_rst_cnt_range: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    rst_active_q |-> (rst_cnt_q >= CNT_W'(1)) && (rst_cnt_q <= CNT_W'(RST_HOLD)))
    else $error("lifecycle reset counter left 1..RST_HOLD");

endmodule : svc_cmd_decoder

`default_nettype wire

/* hw/svc_cmd_pkg.sv */
/*
  Service command codes and the fault request that the decoder sends to the
  partitions. Codes outside this list are ignored.
*/

`default_nettype none

package svc_cmd_pkg;

  typedef enum logic [7:0] {
    CMD_CORR_FAULT    = 8'h01,
    CMD_UNCORR_FAULT  = 8'h02,
    CMD_RELEASE_FAULT = 8'h03,
    CMD_LC_RESET      = 8'h10
  } svc_cmd_e;

  // Kind of fault applied to the locked partitions
  typedef enum logic [1:0] {
    FAULT_NONE   = 2'd0,
    FAULT_CORR   = 2'd1,
    FAULT_UNCORR = 2'd2
  } fault_kind_e;

  typedef struct packed {
    fault_kind_e kind;
  } fault_req_t;

endpackage : svc_cmd_pkg

`default_nettype wire

/* hw/otp_fault_pkg.sv */
/*
  Fuse array types and the Wishbone address map of the test-service block.
  Every partition holds a single 16-bit word, and at most MAX_PART partitions exist.
*/

`default_nettype none

package otp_fault_pkg;

  // ----------------------------------------------------------
  // Bus and array geometry
  // ----------------------------------------------------------
  localparam int ADDR_W   = 5;
  localparam int WB_DW    = 32;
  localparam int MAX_PART = 8;

  // Word addresses, one data and one digest slot per partition
  localparam logic [ADDR_W-1:0] ADDR_DATA_BASE   = 5'h00;
  localparam logic [ADDR_W-1:0] ADDR_DIGEST_BASE = 5'h08;
  localparam logic [ADDR_W-1:0] ADDR_STATUS      = 5'h10;

  // ----------------------------------------------------------
  // Fuse word and per-partition traffic
  // ----------------------------------------------------------
  typedef logic [15:0] otp_word_t;

  // One-cycle write to one partition
  typedef struct packed {
    logic      data_we;
    logic      digest_we;
    otp_word_t wdata;
  } part_wr_t;

  // What a partition reports back after fault classification
  typedef struct packed {
    otp_word_t rdata;
    logic      locked;
    logic      corr;
    logic      uncorr;
  } part_stat_t;

endpackage : otp_fault_pkg

`default_nettype wire
